// ==== design/sram_mem_config.svh ====
// ========================================
// Width macros for the SRAM memory port.
// ========================================

`ifndef SRAM_MEM_CONFIG_SVH
`define SRAM_MEM_CONFIG_SVH

// Half-word address into the SRAM, byte address bits 23 down to 1.
`define SRAM_ADDR_W 23

// External SRAM data bus.
`define SRAM_DATA_W 16

// Processor word.
`define CPU_WORD_W 32

`endif

// ==== design/sram_mem_pkg.sv ====
// ========================================
// Shared types for the SRAM memory port.
// Request, SRAM pin bundle, arbiter state.
// ========================================

`default_nettype none

`include "sram_mem_config.svh"

package sram_mem_pkg;

	// One word access from the arbiter to the sequencer.
	typedef struct packed {
		logic [`CPU_WORD_W-1:0] addr;   // Byte address.
		logic                   write;  // 1 means write.
		logic [`CPU_WORD_W-1:0] wdata;  // Write word.
	} mem_req_t;

	// Outputs towards the asynchronous SRAM.
	typedef struct packed {
		logic [`SRAM_ADDR_W-1:0] addr;   // Half-word address.
		logic                    we_n;   // Write strobe, active low.
		logic                    oe_n;   // Output enable, active low.
		logic [`SRAM_DATA_W-1:0] dq_out; // Write data.
		logic                    dq_oe;  // We drive the data bus.
	} sram_pins_t;

	// Which processor port is being served.
	typedef enum logic [1:0] {
		IDLE,
		INSTR,
		DATA
	} port_state_t;

endpackage

`default_nettype wire

// ==== design/cpu_port_arbiter.sv ====
// ========================================
// Processor side arbiter. Instruction first,
// registered stall, result word registers.
// ========================================

`timescale 1ns/100ps
`default_nettype none

`include "sram_mem_config.svh"

module cpu_port_arbiter
	import sram_mem_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst,
	// Processor ports.
	input  logic                   ie,     // Instruction fetch enable.
	input  logic                   de,     // Data access enable.
	input  logic [`CPU_WORD_W-1:0] iaddr,
	input  logic [`CPU_WORD_W-1:0] daddr,
	input  logic                   drw,    // 1 means write.
	input  logic [`CPU_WORD_W-1:0] din,
	output logic [`CPU_WORD_W-1:0] iout,
	output logic [`CPU_WORD_W-1:0] dout,
	output logic                   stall,
	// Sequencer side.
	input  logic                   done,
	input  logic [`CPU_WORD_W-1:0] rdata,
	output logic                   start,
	output mem_req_t               req
);

	port_state_t state;
	port_state_t state_nxt;
	logic        issued; // Start already strobed in this state.

	// ========================================
	// Port FSM
	// ========================================

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (ie) begin
					state_nxt = INSTR; // Fetch always goes first.
				end else if (de) begin
					state_nxt = DATA;
				end
			end
			INSTR: begin
				if (done) begin
					state_nxt = de ? DATA : IDLE; // Chain the data access if pending.
				end
			end
			DATA: begin
				if (done) begin
					state_nxt = IDLE;
				end
			end
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state  <= IDLE;
			issued <= 1'b0;
			stall  <= 1'b0;
		end else begin
			state <= state_nxt;
			stall <= (state_nxt != IDLE); // High for every busy state.
			if (state_nxt != state) begin
				issued <= 1'b0; // New state, new access.
			end else if (start) begin
				issued <= 1'b1;
			end
		end
	end

	// One strobe per non-idle state, first cycle in it.
	assign start = (state != IDLE) && !issued;

	// ========================================
	// Request and results
	// ========================================

	// Inputs are held by the processor, so no request register here.
	always_comb begin
		req.addr  = (state == DATA) ? daddr : iaddr;
		req.write = (state == DATA) && drw; // Fetches never write.
		req.wdata = din;
	end

	// Result words hold until the next access of their port.
	always_ff @(posedge clk) begin
		if (done && state == INSTR) begin
			iout <= rdata;
		end
		if (done && state == DATA && !req.write) begin
			dout <= rdata; // Writes leave dout alone.
		end
	end

endmodule

`default_nettype wire

// ==== design/sram_word_sequencer.sv ====
// ========================================
// Word sequencer. Two half-word SRAM cycles
// per access, drives the SRAM pins.
// ========================================

`timescale 1ns/100ps
`default_nettype none

`include "sram_mem_config.svh"

module sram_word_sequencer
	import sram_mem_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    start, // Accepted only while idle.
	input  mem_req_t                req,
	input  logic [`SRAM_DATA_W-1:0] dq_in,
	output sram_pins_t              pins,
	output logic [`CPU_WORD_W-1:0]  rdata,
	output logic                    done
);

	// Read phases.  0 upper addr, 1 upper capture, 2 lower addr, 3 lower capture.
	// Write phases. 0 setup, 1 we_n low, 2 hold, then the same for the lower half.
	localparam logic [2:0] RD_LAST = 3'd3;
	localparam logic [2:0] WR_LAST = 3'd5;

	logic                    busy;   // An access is running.
	logic [2:0]              phase;
	mem_req_t                req_q;  // Latched request.
	logic [`SRAM_DATA_W-1:0] hi_q;   // Upper half of a read.
	logic                    last;   // Final cycle of the access.
	logic                    half;   // 0 upper half, 1 lower half.
	logic                    we_ph;  // Write strobe phase.

	assign last  = busy && (phase == (req_q.write ? WR_LAST : RD_LAST));
	assign half  = req_q.write ? (phase >= 3'd3) : (phase >= 3'd2);
	assign we_ph = (phase == 3'd1) || (phase == 3'd4);

	// ========================================
	// Control
	// ========================================

	always_ff @(posedge clk) begin
		if (rst) begin
			busy  <= 1'b0;
			phase <= 3'd0;
		end else if (!busy) begin
			if (start) begin
				busy  <= 1'b1;
				phase <= 3'd0;
			end
		end else if (last) begin
			busy  <= 1'b0; // Idle again the cycle after done.
			phase <= 3'd0;
		end else begin
			phase <= phase + 3'd1;
		end
	end

	// ========================================
	// Payload
	// ========================================

	always_ff @(posedge clk) begin
		if (!busy && start) begin
			req_q <= req;
		end
		// Upper half settled after a full address cycle.
		if (busy && !req_q.write && phase == 3'd1) begin
			hi_q <= dq_in;
		end
	end

	// ========================================
	// SRAM pins
	// ========================================

	always_comb begin
		pins.addr   = {req_q.addr[`SRAM_ADDR_W:2], half}; // Word address plus half select.
		pins.dq_out = half ? req_q.wdata[`SRAM_DATA_W-1:0]
		                   : req_q.wdata[`CPU_WORD_W-1:`SRAM_DATA_W];
		pins.dq_oe  = busy && req_q.write;            // Bus driven for whole write.
		pins.oe_n   = !(busy && !req_q.write);        // Reads keep output on.
		pins.we_n   = !(busy && req_q.write && we_ph); // Setup and hold around strobe.
	end

	// Lower half is taken straight off the bus in the capture cycle.
	assign rdata = {hi_q, dq_in};
	assign done  = last;

endmodule

`default_nettype wire

// ==== design/sram_mem_top.sv ====
// ========================================
// Memory port top. Arbiter and sequencer.
// ========================================

`timescale 1ns/100ps
`default_nettype none

`include "sram_mem_config.svh"

module sram_mem_top
	import sram_mem_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst,
	// Processor ports.
	input  logic                    ie,
	input  logic                    de,
	input  logic [`CPU_WORD_W-1:0]  iaddr,
	input  logic [`CPU_WORD_W-1:0]  daddr,
	input  logic                    drw,
	input  logic [`CPU_WORD_W-1:0]  din,
	output logic [`CPU_WORD_W-1:0]  iout,
	output logic [`CPU_WORD_W-1:0]  dout,
	output logic                    stall,
	// SRAM side.
	input  logic [`SRAM_DATA_W-1:0] sram_dq_in,
	output sram_pins_t              sram_pins,
	output logic                    sram_ce_n,
	output logic                    sram_lb_n,
	output logic                    sram_ub_n,
	output logic                    sram_adv_n,
	output logic                    sram_cre,
	output logic                    sram_clk
);

	logic                   start;
	mem_req_t               req;
	logic [`CPU_WORD_W-1:0] rdata;
	logic                   done;

	// Static controls for plain asynchronous mode.
	assign sram_ce_n  = 1'b0; // Chip always selected.
	assign sram_lb_n  = 1'b0; // Full half-word transfers only.
	assign sram_ub_n  = 1'b0;
	assign sram_adv_n = 1'b0; // Address flows through.
	assign sram_cre   = 1'b0; // No config register access.
	assign sram_clk   = 1'b0;

	cpu_port_arbiter cpu_port_arbiter_inst (
		.clk   (clk),
		.rst   (rst),
		.ie    (ie),
		.de    (de),
		.iaddr (iaddr),
		.daddr (daddr),
		.drw   (drw),
		.din   (din),
		.iout  (iout),
		.dout  (dout),
		.stall (stall),
		.done  (done),
		.rdata (rdata),
		.start (start),
		.req   (req)
	);

	sram_word_sequencer sram_word_sequencer_inst (
		.clk   (clk),
		.rst   (rst),
		.start (start),
		.req   (req),
		.dq_in (sram_dq_in),
		.pins  (sram_pins),
		.rdata (rdata),
		.done  (done)
	);

endmodule

`default_nettype wire

// ==== dv/sram_model.sv ====
// ========================================
// Asynchronous 16-bit SRAM model.
// ========================================

`timescale 1ns/100ps
`default_nettype none

`include "sram_mem_config.svh"

module sram_model
	import sram_mem_pkg::*;
(
	input  sram_pins_t              pins,
	output logic [`SRAM_DATA_W-1:0] dq
);

	localparam int DEPTH = 512; // 256 words, two halves each.

	logic [`SRAM_DATA_W-1:0] cells [DEPTH];
	logic                    we_n;
	logic [31:0]             pat;

	assign we_n = pins.we_n;

	// Power-up contents, a pattern over the whole half-word index.
	initial begin
		for (int i = 0; i < DEPTH; i++) begin
			pat = i * 32'h0000b5c3 + 32'h00006e1d;
			cells[9'(i)] = pat[15:0] ^ pat[31:16];
		end
	end

	// Write lands at the rising edge of the strobe.
	always @(posedge we_n) begin
		if (pins.dq_oe) begin
			cells[pins.addr[8:0]] <= pins.dq_out;
		end
	end

	// Output only while enabled and nobody else drives the bus.
	assign dq = (!pins.oe_n && !pins.dq_oe) ? cells[pins.addr[8:0]] : '0;

endmodule

`default_nettype wire

// ==== dv/sram_mem_checker.sv ====
// ========================================
// Protocol assertions on the word sequencer.
// ========================================

`timescale 1ns/100ps
`default_nettype none

module sram_mem_checker
	import sram_mem_pkg::*;
(
	input logic       clk,
	input logic       rst,
	input logic       start,
	input logic       busy,
	input logic       done,
	input mem_req_t   req,
	input sram_pins_t pins
);

	logic seen_start; // A start was accepted since reset.
	logic wr_active;  // Accepted write not yet finished.

	always_ff @(posedge clk) begin
		if (rst) begin
			seen_start <= 1'b0;
		end else if (start) begin
			seen_start <= 1'b1;
		end
	end

	// Follows the request as handed over, not the latched copy.
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_active <= 1'b0;
		end else if (start && !busy) begin
			wr_active <= req.write;
		end else if (done) begin
			wr_active <= 1'b0;
		end
	end

	done_one_cycle: assert property (@(posedge clk) disable iff (rst) done |=> !done)
		else $error("done stayed high for more than one cycle");

	dq_oe_on_write: assert property (@(posedge clk) disable iff (rst)
		pins.dq_oe |-> wr_active)
		else $error("data bus driven outside a write");

	// A strobe needs the SRAM output off and our data on the bus.
	we_oe_exclusive: assert property (@(posedge clk) disable iff (rst)
		!pins.we_n |-> (pins.oe_n && pins.dq_oe && wr_active))
		else $error("we_n low while SRAM output or bus drive is wrong");

	// One cycle strobe, address and data held into the next cycle.
	we_hold: assert property (@(posedge clk) disable iff (rst)
		!pins.we_n |=> (pins.we_n && pins.dq_oe
			&& $stable(pins.addr) && $stable(pins.dq_out)))
		else $error("address or data changed around the write strobe");

	no_done_before_start: assert property (@(posedge clk) disable iff (rst)
		!seen_start |-> !done)
		else $error("done before any start");

endmodule

bind sram_word_sequencer sram_mem_checker sram_mem_checker_inst (
	.clk   (clk),
	.rst   (rst),
	.start (start),
	.busy  (busy),
	.done  (done),
	.req   (req),
	.pins  (pins)
);

`default_nettype wire

// ==== dv/sram_mem_tb.sv ====
// ========================================
// Testbench for the SRAM memory port.
// ========================================

`timescale 1ns/100ps
`default_nettype none

module sram_mem_tb
	import sram_mem_pkg::*;
();

	localparam int STALL_TIMEOUT = 40; // Cycles per stall edge.

	logic        clk, rst, ie, de, drw, stall;
	logic [31:0] iaddr, daddr, din, iout, dout;
	logic [15:0] sram_dq_in;
	sram_pins_t  sram_pins;
	logic        sram_ce_n, sram_lb_n, sram_ub_n, sram_adv_n, sram_cre, sram_clk;

	logic [31:0] ref_mem [256]; // Reference word memory.
	logic [31:0] rng;
	logic [31:0] iout_exp, dout_exp;
	logic        iout_valid, dout_valid; // Port has returned a word since reset.
	logic        timed_out;              // A stall wait ran out.
	int          errors, checks;

	initial clk = 1'b0;
	always #2 clk = ~clk;

	sram_mem_top sram_mem_top_inst (
		.clk(clk), .rst(rst), .ie(ie), .de(de), .iaddr(iaddr), .daddr(daddr),
		.drw(drw), .din(din), .iout(iout), .dout(dout), .stall(stall),
		.sram_dq_in(sram_dq_in), .sram_pins(sram_pins), .sram_ce_n(sram_ce_n),
		.sram_lb_n(sram_lb_n), .sram_ub_n(sram_ub_n), .sram_adv_n(sram_adv_n),
		.sram_cre(sram_cre), .sram_clk(sram_clk)
	);

	sram_model sram_model_inst (.pins(sram_pins), .dq(sram_dq_in));

	// ========================================
	// Helpers
	// ========================================

	function automatic logic [31:0] next_random();
		logic [31:0] x;
		x = rng;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng = x;
		return x;
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic finish_run();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	endtask

	// Steps edge by edge, samples just after each edge.
	task automatic wait_stall(input logic level);
		int n;
		n = 0;
		do begin
			@(posedge clk);
			#0.5;
			n++;
		end while (stall !== level && n < STALL_TIMEOUT);
		if (stall !== level) begin
			errors++;
			timed_out = 1'b1;
			$display("Timeout: stall never went to %0d", level);
		end
	endtask

	// One processor request, held until stall rises and falls.
	task automatic serve(input logic i_en, input logic d_en, input logic [7:0] i_idx,
			input logic [7:0] d_idx, input logic rw, input logic [31:0] wd);
		logic [31:0] i_exp;
		if (timed_out) begin
			return;
		end
		i_exp = ref_mem[i_idx]; // Fetch is served before the data access.
		ie    = i_en;
		de    = d_en;
		iaddr = {22'd0, i_idx, 2'b00};
		daddr = {22'd0, d_idx, 2'b00};
		drw   = rw;
		din   = wd;
		wait_stall(1'b1);
		if (!timed_out) begin
			wait_stall(1'b0);
		end
		ie  = 1'b0;
		de  = 1'b0;
		drw = 1'b0;
		if (timed_out) begin
			return;
		end
		if (i_en) begin
			iout_exp   = i_exp;
			iout_valid = 1'b1;
		end
		if (d_en && rw) begin
			ref_mem[d_idx] = wd;
		end else if (d_en) begin
			dout_exp   = ref_mem[d_idx];
			dout_valid = 1'b1;
		end
		if (iout_valid) check_value("iout", iout_exp, iout);
		if (dout_valid) check_value("dout", dout_exp, dout); // Unchanged unless read.
	endtask

	// ========================================
	// Stimulus
	// ========================================

	initial begin
		logic [31:0] r;
		logic [31:0] wd;
		rng = 32'h47f3;
		errors = 0;
		checks = 0;
		timed_out = 1'b0;
		iout_valid = 1'b0;
		dout_valid = 1'b0;
		iout_exp = '0;
		dout_exp = '0;
		rst = 1'b1;
		ie = 1'b0;
		de = 1'b0;
		iaddr = '0;
		daddr = '0;
		drw = 1'b0;
		din = '0;
		repeat (2) @(posedge clk);
		#0.5;
		rst = 1'b0;
		check_value("stall", 32'd0, {31'd0, stall});
		check_value("sram_pins.we_n", 32'd1, {31'd0, sram_pins.we_n});
		check_value("sram_pins.oe_n", 32'd1, {31'd0, sram_pins.oe_n});
		check_value("sram_pins.dq_oe", 32'd0, {31'd0, sram_pins.dq_oe});
		// Asynchronous mode static levels.
		check_value("sram_ce_n", 32'd0, {31'd0, sram_ce_n});
		check_value("sram_lb_n", 32'd0, {31'd0, sram_lb_n});
		check_value("sram_ub_n", 32'd0, {31'd0, sram_ub_n});
		check_value("sram_adv_n", 32'd0, {31'd0, sram_adv_n});
		check_value("sram_cre", 32'd0, {31'd0, sram_cre});
		check_value("sram_clk", 32'd0, {31'd0, sram_clk});
		for (int w = 0; w < 256; w++) begin // Upper half sits at half select 0.
			ref_mem[8'(w)] = {sram_model_inst.cells[9'(2 * w)],
			                  sram_model_inst.cells[9'(2 * w + 1)]};
		end
		serve(1'b0, 1'b1, 8'd0, 8'd5, 1'b1, 32'hcafe_0123); // Write, then read back.
		serve(1'b0, 1'b1, 8'd0, 8'd5, 1'b0, 32'd0);
		serve(1'b1, 1'b0, 8'd9, 8'd0, 1'b0, 32'd0);
		serve(1'b1, 1'b1, 8'd12, 8'd30, 1'b1, 32'h1357_9bdf);
		serve(1'b0, 1'b1, 8'd0, 8'd30, 1'b0, 32'd0);
		serve(1'b1, 1'b1, 8'd40, 8'd40, 1'b0, 32'd0); // Same address on both ports.
		serve(1'b1, 1'b1, 8'd41, 8'd77, 1'b0, 32'd0);
		for (int k = 0; k < 200 && !timed_out; k++) begin
			r  = next_random();
			wd = next_random();
			case (r[1:0])
				2'd0:    serve(1'b1, 1'b0, r[9:2], r[17:10], 1'b0, wd);
				2'd1:    serve(1'b0, 1'b1, r[9:2], r[17:10], r[18], wd);
				default: serve(1'b1, 1'b1, r[9:2], r[17:10], r[18], wd);
			endcase
		end
		finish_run();
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+design
design/sram_mem_pkg.sv
design/cpu_port_arbiter.sv
design/sram_word_sequencer.sv
design/sram_mem_top.sv
dv/sram_model.sv
dv/sram_mem_checker.sv
dv/sram_mem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the SRAM memory port testbench with Verilator.

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert -f filelist.f \
	--top-module sram_mem_tb --Mdir "$build_dir" -o sram_mem_sim
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

"./$build_dir/sram_mem_sim" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Regression passed" "$log"; then
	exit 0
fi
exit 1
